/* hdl/commit_pkg.sv */
`default_nettype none

package commit_pkg;

  localparam int xlen  = 32;
  localparam int nregs = 16;

  typedef logic [3:0] reg_idx_t;

  ////////////////////
  // encodings

  typedef enum logic [2:0] {
    op_normal,
    op_ecall,
    op_mret,
    op_fence_i,
    op_misaligned
  } commit_op_e;

  typedef enum logic [11:0] {
    csr_mstatus   = 12'h300,
    csr_mtvec     = 12'h305,
    csr_mepc      = 12'h341,
    csr_mcause    = 12'h342,
    csr_mvendorid = 12'hF11,
    csr_marchid   = 12'hF12
  } csr_addr_e;

  ////////////////////
  // records

  typedef struct packed {
    commit_op_e      op;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pred_npc; // next pc from execute
    logic            mispredict;
    reg_idx_t        rd;
    logic            rd_wen;
    logic [xlen-1:0] rd_wdata;
    logic [11:0]     csr_addr;
    logic            csr_wen;
    logic [xlen-1:0] csr_wdata;
  } commit_t;

  typedef struct packed {
    logic [xlen-1:0] npc;
    logic            flush;
    logic            flush_icache;
  } redirect_t;

  typedef struct packed {
    logic            take;
    logic [xlen-1:0] cause;
    logic [xlen-1:0] epc;
  } trap_t;

  ////////////////////
  // reset and fixed values

  localparam logic [xlen-1:0] mstatus_reset   = 32'h0000_1800; // mpp = machine
  localparam logic [xlen-1:0] mvendorid_value = 32'h7973_7978;
  localparam logic [xlen-1:0] marchid_value   = 32'h017D_9F58;

  localparam logic [xlen-1:0] cause_misaligned = 32'd0;
  localparam logic [xlen-1:0] cause_ecall      = 32'd11;

endpackage

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        gpr_wen,
  input  commit_pkg::reg_idx_t        gpr_waddr,
  input  logic [commit_pkg::xlen-1:0] gpr_wdata,
  input  commit_pkg::reg_idx_t        rs1,
  input  commit_pkg::reg_idx_t        rs2,
  output logic [commit_pkg::xlen-1:0] src1,
  output logic [commit_pkg::xlen-1:0] src2
);
  import commit_pkg::*;

  logic [xlen-1:0] regs [nregs];

  // async read, x0 is never written so it stays zero
  assign src1 = regs[rs1];
  assign src2 = regs[rs2];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (gpr_wen && (gpr_waddr != '0)) begin
      regs[gpr_waddr] <= gpr_wdata;
    end
  end

endmodule

`default_nettype wire

/* hdl/csr_file.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_file (
  input  logic                        clock,
  input  logic                        reset,
  input  logic [11:0]                 csr_raddr,
  input  logic                        csr_wen,
  input  commit_pkg::csr_addr_e       csr_waddr,
  input  logic [commit_pkg::xlen-1:0] csr_wdata,
  input  commit_pkg::trap_t           trap,
  output logic [commit_pkg::xlen-1:0] csr_rdata,
  output logic [commit_pkg::xlen-1:0] mtvec,
  output logic [commit_pkg::xlen-1:0] mepc
);
  import commit_pkg::*;

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mcause;

  ////////////////////
  // write side

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= mstatus_reset;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (trap.take) begin
      mepc   <= trap.epc;
      mcause <= trap.cause;
    end else if (csr_wen) begin
      case (csr_waddr)
        csr_mstatus: mstatus <= csr_wdata;
        csr_mtvec:   mtvec   <= csr_wdata;
        csr_mepc:    mepc    <= csr_wdata;
        default: ; // mcause and id regs not software writable here
      endcase
    end
  end

  ////////////////////
  // read side

  always_comb begin
    case (csr_raddr)
      csr_mstatus:   csr_rdata = mstatus;
      csr_mtvec:     csr_rdata = mtvec;
      csr_mepc:      csr_rdata = mepc;
      csr_mcause:    csr_rdata = mcause;
      csr_mvendorid: csr_rdata = mvendorid_value;
      csr_marchid:   csr_rdata = marchid_value;
      default:       csr_rdata = '0; // unknown csr
    endcase
  end

endmodule

`default_nettype wire

/* hdl/commit_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module commit_ctrl (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        commit_valid,
  input  commit_pkg::commit_t         commit,
  input  logic [commit_pkg::xlen-1:0] mtvec,
  input  logic [commit_pkg::xlen-1:0] mepc,
  output logic                        gpr_wen,
  output commit_pkg::reg_idx_t        gpr_waddr,
  output logic [commit_pkg::xlen-1:0] gpr_wdata,
  output logic                        csr_wen,
  output commit_pkg::csr_addr_e       csr_waddr,
  output logic [commit_pkg::xlen-1:0] csr_wdata,
  output commit_pkg::trap_t           trap,
  output logic                        redirect_valid,
  output commit_pkg::redirect_t       redirect
);
  import commit_pkg::*;

  logic            accept;
  logic            is_trap;
  logic            next_flush;
  logic            next_flush_icache;
  logic [xlen-1:0] next_npc;
  logic            flush_q;
  logic            flush_icache_q;
  logic [xlen-1:0] npc_q;

  // record behind a flush belongs to a squashed instruction
  assign accept  = commit_valid && !flush_q;
  assign is_trap = (commit.op == op_ecall) || (commit.op == op_misaligned);

  ////////////////////
  // write enables

  assign gpr_wen   = accept && !is_trap && commit.rd_wen && (commit.rd != '0);
  assign gpr_waddr = commit.rd;
  assign gpr_wdata = commit.rd_wdata;

  assign csr_wen   = accept && !is_trap && commit.csr_wen;
  assign csr_waddr = csr_addr_e'(commit.csr_addr);
  assign csr_wdata = commit.csr_wdata;

  assign trap = '{
    take:  accept && is_trap,
    cause: (commit.op == op_misaligned) ? cause_misaligned : cause_ecall,
    epc:   commit.pc
  };

  ////////////////////
  // redirect

  always_comb begin
    next_flush_icache = 1'b0;
    if (is_trap) begin
      next_npc   = mtvec;
      next_flush = 1'b1;
    end else begin
      next_npc          = (commit.op == op_mret) ? mepc : commit.pred_npc;
      next_flush        = (commit.op == op_mret) || (commit.op == op_fence_i) ||
                          commit.mispredict;
      next_flush_icache = (commit.op == op_fence_i);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      redirect_valid <= 1'b0;
      flush_q        <= 1'b0;
      flush_icache_q <= 1'b0;
    end else begin
      redirect_valid <= accept;
      flush_q        <= accept && next_flush; // one cycle, clears itself
      flush_icache_q <= accept && next_flush_icache;
    end
  end

  always_ff @(posedge clock) begin
    npc_q <= next_npc;
  end

  assign redirect = '{npc: npc_q, flush: flush_q, flush_icache: flush_icache_q};

endmodule

`default_nettype wire

/* hdl/commit_top.sv */
`timescale 1ns/1ns
`default_nettype none

module commit_top (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        commit_valid,
  input  commit_pkg::commit_t         commit,
  input  commit_pkg::reg_idx_t        rs1,
  input  commit_pkg::reg_idx_t        rs2,
  input  logic [11:0]                 csr_raddr,
  output logic [commit_pkg::xlen-1:0] src1,
  output logic [commit_pkg::xlen-1:0] src2,
  output logic [commit_pkg::xlen-1:0] csr_rdata,
  output logic                        redirect_valid,
  output commit_pkg::redirect_t       redirect
);
  import commit_pkg::*;

  logic            gpr_wen;
  reg_idx_t        gpr_waddr;
  logic [xlen-1:0] gpr_wdata;
  logic            csr_wen;
  csr_addr_e       csr_waddr;
  logic [xlen-1:0] csr_wdata;
  trap_t           trap;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;

  commit_ctrl u_commit_ctrl (
    .clock, .reset, .commit_valid, .commit, .mtvec, .mepc,
    .gpr_wen, .gpr_waddr, .gpr_wdata,
    .csr_wen, .csr_waddr, .csr_wdata, .trap,
    .redirect_valid, .redirect
  );

  reg_file u_reg_file (
    .clock, .reset, .gpr_wen, .gpr_waddr, .gpr_wdata,
    .rs1, .rs2, .src1, .src2
  );

  // mtvec and mepc feed back for the redirect target
  csr_file u_csr_file (
    .clock, .reset, .csr_raddr, .csr_wen, .csr_waddr, .csr_wdata,
    .trap, .csr_rdata, .mtvec, .mepc
  );

endmodule

`default_nettype wire

/* dv/commit_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module commit_chk (
  input logic                  clock,
  input logic                  reset,
  input logic                  redirect_valid,
  input commit_pkg::redirect_t redirect
);

  ////////////////////
  // flush pulse shape

  flush_one_cycle: assert property (
    @(posedge clock) disable iff (reset)
    redirect.flush |=> !redirect.flush
  ) else $error("flush held high for two cycles in a row");

  // record behind a flush is squashed
  no_redirect_after_flush: assert property (
    @(posedge clock) disable iff (reset)
    redirect.flush |=> !redirect_valid
  ) else $error("redirect_valid high in the cycle after a flush");

  icache_needs_flush: assert property (
    @(posedge clock) disable iff (reset)
    redirect.flush_icache |-> redirect.flush
  ) else $error("flush_icache high without flush");

  ////////////////////
  // reset

  quiet_after_reset: assert property (
    @(posedge clock)
    reset |=> !redirect_valid
  ) else $error("redirect_valid high in the cycle after reset");

endmodule

`default_nettype wire

/* dv/commit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module commit_tb;
  import commit_pkg::*;

  localparam int num_commits = 400;
  localparam int stim_cycles = 5 + num_commits + 2 * nregs;
  localparam int cycle_limit = 2 * stim_cycles + 100;

  logic            clock;
  logic            reset;
  logic            commit_valid;
  commit_t         commit;
  reg_idx_t        rs1;
  reg_idx_t        rs2;
  logic [11:0]     csr_raddr;
  logic [xlen-1:0] src1;
  logic [xlen-1:0] src2;
  logic [xlen-1:0] csr_rdata;
  logic            redirect_valid;
  redirect_t       redirect;

  // reference model state
  logic [xlen-1:0] m_regs [nregs];
  logic [xlen-1:0] m_mstatus, m_mtvec, m_mepc, m_mcause;
  logic            flush_pending;
  logic            exp_valid, exp_flush, exp_icache;
  logic [xlen-1:0] exp_npc;

  int unsigned seed;
  int          cycles;
  int          err_redirect, err_gpr, err_csr;

  commit_top u_commit_top (
    .clock, .reset, .commit_valid, .commit, .rs1, .rs2, .csr_raddr,
    .src1, .src2, .csr_rdata, .redirect_valid, .redirect
  );

  bind commit_ctrl commit_chk u_commit_chk (
    .clock(clock), .reset(reset), .redirect_valid(redirect_valid), .redirect(redirect)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  ////////////////////
  // stimulus helpers

  // every implemented csr plus two unknown addresses
  function automatic logic [11:0] csr_addr_at(int sel);
    case (sel % 8)
      0: return csr_mstatus;
      1: return csr_mtvec;
      2: return csr_mepc;
      3: return csr_mcause;
      4: return csr_mvendorid;
      5: return csr_marchid;
      6: return 12'h7C0; // unimplemented
      default: return 12'h001;
    endcase
  endfunction

  function automatic logic [11:0] random_csr_addr();
    return csr_addr_at($urandom_range(0, 7));
  endfunction

  function automatic commit_t random_commit();
    commit_t rec;
    rec = '0;
    case ($urandom_range(0, 15))
      0: rec.op = op_ecall;
      1: rec.op = op_misaligned;
      2: rec.op = op_mret;
      3: rec.op = op_fence_i;
      default: rec.op = op_normal;
    endcase
    rec.pc         = $urandom() & 32'hFFFF_FFFC;
    rec.pred_npc   = $urandom() & 32'hFFFF_FFFC;
    rec.mispredict = ($urandom_range(0, 7) == 0);
    rec.rd         = $urandom_range(0, nregs - 1);
    rec.rd_wen     = ($urandom_range(0, 3) != 0);
    rec.rd_wdata   = $urandom();
    rec.csr_addr   = random_csr_addr();
    rec.csr_wen    = ($urandom_range(0, 3) == 0);
    rec.csr_wdata  = $urandom();
    if (rec.op == op_misaligned) rec.pc[1] = 1'b1; // half-word target
    return rec;
  endfunction

  ////////////////////
  // model and checks

  function automatic logic [xlen-1:0] csr_expected(logic [11:0] addr);
    case (addr)
      csr_mstatus:   return m_mstatus;
      csr_mtvec:     return m_mtvec;
      csr_mepc:      return m_mepc;
      csr_mcause:    return m_mcause;
      csr_mvendorid: return mvendorid_value;
      csr_marchid:   return marchid_value;
      default:       return '0;
    endcase
  endfunction

  task automatic update_model(logic valid, commit_t rec);
    logic accepted;
    logic is_trap;
    accepted   = valid && !flush_pending;
    is_trap    = (rec.op == op_ecall) || (rec.op == op_misaligned);
    exp_valid  = accepted;
    exp_flush  = 1'b0;
    exp_icache = 1'b0;
    if (accepted && is_trap) begin
      exp_npc   = m_mtvec;
      exp_flush = 1'b1;
      m_mepc    = rec.pc;
      m_mcause  = (rec.op == op_misaligned) ? cause_misaligned : cause_ecall;
    end else if (accepted) begin
      exp_npc    = (rec.op == op_mret) ? m_mepc : rec.pred_npc; // old mepc
      exp_flush  = (rec.op == op_mret) || (rec.op == op_fence_i) || rec.mispredict;
      exp_icache = (rec.op == op_fence_i);
      if (rec.rd_wen && rec.rd != 0) m_regs[rec.rd] = rec.rd_wdata;
      if (rec.csr_wen) begin
        case (rec.csr_addr)
          csr_mstatus: m_mstatus = rec.csr_wdata;
          csr_mtvec:   m_mtvec   = rec.csr_wdata;
          csr_mepc:    m_mepc    = rec.csr_wdata;
          default: ;
        endcase
      end
    end
    flush_pending = exp_flush;
  endtask

  task automatic check_redirect();
    assert (redirect_valid === exp_valid) else begin
      err_redirect++;
      $display("Fail %0t: redirect_valid %b, expected %b", $time, redirect_valid, exp_valid);
    end
    assert (redirect.flush === exp_flush && redirect.flush_icache === exp_icache) else begin
      err_redirect++;
      $display("Fail %0t: flush/flush_icache %b/%b, expected %b/%b", $time,
               redirect.flush, redirect.flush_icache, exp_flush, exp_icache);
    end
    if (exp_valid) begin
      assert (redirect.npc === exp_npc) else begin
        err_redirect++;
        $display("Fail %0t: npc %h, expected %h", $time, redirect.npc, exp_npc);
      end
    end
  endtask

  task automatic check_reads();
    assert (src1 === m_regs[rs1] && src2 === m_regs[rs2]) else begin
      err_gpr++;
      $display("Fail %0t: x%0d=%h x%0d=%h, expected %h %h", $time, rs1, src1, rs2, src2,
               m_regs[rs1], m_regs[rs2]);
    end
    assert (csr_rdata === csr_expected(csr_raddr)) else begin
      err_csr++;
      $display("Fail %0t: csr %h reads %h, expected %h", $time, csr_raddr, csr_rdata,
               csr_expected(csr_raddr));
    end
  endtask

  // one clock of stimulus, driven on the falling edge
  task automatic run_cycle(logic valid, commit_t rec, reg_idx_t r1, reg_idx_t r2,
                           logic [11:0] caddr);
    @(negedge clock);
    check_redirect();
    commit_valid = valid;
    commit       = rec;
    rs1          = r1;
    rs2          = r2;
    csr_raddr    = caddr;
    #1;
    check_reads();
    update_model(valid, rec);
  endtask

  ////////////////////
  // main sequence

  initial begin
    reset         = 1'b1;
    commit_valid  = 1'b0;
    commit        = '0;
    rs1           = '0;
    rs2           = '0;
    csr_raddr     = '0;
    err_redirect  = 0;
    err_gpr       = 0;
    err_csr       = 0;
    flush_pending = 1'b0;
    exp_valid     = 1'b0;
    exp_flush     = 1'b0;
    exp_icache    = 1'b0;
    exp_npc       = '0;
    for (int i = 0; i < nregs; i++) m_regs[i] = '0;
    m_mstatus = mstatus_reset;
    m_mtvec   = '0;
    m_mepc    = '0;
    m_mcause  = '0;
    seed = 32'hb52c;
    void'($urandom(seed));

    repeat (5) @(negedge clock);
    reset = 1'b0;

    // reset state of every register and csr
    for (int i = 0; i < nregs; i++) begin
      run_cycle(1'b0, commit, i, nregs - 1 - i, csr_addr_at(i));
    end

    for (int n = 0; n < num_commits; n++) begin
      run_cycle(($urandom_range(0, 7) != 0), random_commit(), $urandom_range(0, nregs - 1),
                $urandom_range(0, nregs - 1), random_csr_addr());
    end

    // final sweep with the stage idle
    for (int i = 0; i < nregs; i++) begin
      run_cycle(1'b0, commit, i, nregs - 1 - i, csr_addr_at(i));
    end
    @(negedge clock);
    check_redirect();

    $display("errors: redirect %0d, gpr %0d, csr %0d", err_redirect, err_gpr, err_csr);
    if (err_redirect + err_gpr + err_csr == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* commit_top.f */
hdl/commit_pkg.sv
hdl/reg_file.sv
hdl/csr_file.sv
hdl/commit_ctrl.sv
hdl/commit_top.sv
dv/commit_chk.sv
dv/commit_tb.sv

/* Bender.yml */
package:
  name: commit_stage

sources:
  - hdl/commit_pkg.sv
  - hdl/reg_file.sv
  - hdl/csr_file.sv
  - hdl/commit_ctrl.sv
  - hdl/commit_top.sv
  - target: test
    files:
      - dv/commit_chk.sv
      - dv/commit_tb.sv
